/* hdl/tcp_tx_defs.svh */
`ifndef TCP_TX_DEFS_SVH
`define TCP_TX_DEFS_SVH

// advertised receive window, fixed for now
`define TCP_DEFAULT_WND 16'd1000

// header is always 20 bytes, no options
`define TCP_HDR_BYTES 20

// data offset in 32-bit words
`define TCP_DEFAULT_OFFSET 4'd5

// flag bits
`define TCP_FLAG_ACK 8'h10
`define TCP_FLAG_PSH 8'h08

// quiet cycles before a keep-alive goes out
`define TCP_KA_TICKS 64

`endif

/* hdl/tcp_tx_pkg.sv */
package tcp_tx_pkg;

  typedef logic [31:0] tcp_num_t;   // seq / ack numbers
  typedef logic [15:0] tcp_port_t;
  typedef logic [7:0]  tcp_flags_t;
  typedef logic [15:0] tcp_wnd_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  hdr_idx_t;   // 0..19

  // segment kinds the arbiter can send
  typedef enum logic [2:0] {
    tx_none,
    tx_pld,
    tx_ka,
    tx_ack,
    tx_eng
  } tx_kind_t;

  typedef enum logic [1:0] {
    idle_s,
    active_s,
    sent_s
  } arb_state_t;

  // four-phase byte output
  typedef enum logic [1:0] {
    ser_idle,
    ser_req,
    ser_wait_low,
    ser_done
  } ser_state_t;

endpackage : tcp_tx_pkg

/* hdl/tcp_meta_if.sv */
`timescale 1ns/100ps

interface tcp_meta_if import tcp_tx_pkg::*; ();

  logic       rdy;
  logic       acc;   // fields taken
  logic       done;  // last byte out
  tcp_num_t   seq;
  tcp_num_t   ack_num;
  tcp_flags_t flags;
  tcp_port_t  src_port;
  tcp_port_t  dst_port;

  modport arb (
    output rdy, seq, ack_num, flags, src_port, dst_port,
    input  acc, done
  );

  modport ser (
    input  rdy, seq, ack_num, flags, src_port, dst_port,
    output acc, done
  );

endinterface : tcp_meta_if

/* hdl/tcp_ka_timer.sv */
`timescale 1ns/100ps

`include "tcp_tx_defs.svh"

module tcp_ka_timer #(
  parameter int KA_TICKS = `TCP_KA_TICKS
) (
  input  logic clk,
  input  logic rst,
  input  logic connected,
  input  logic busy,      // segment in flight
  input  logic seg_sent,
  output logic ka_req
);

  localparam int CW = $clog2(KA_TICKS + 1);
  localparam logic [CW-1:0] KA_LIMIT = CW'(KA_TICKS);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt    <= '0;
      ka_req <= 1'b0;
    end else if (!connected || seg_sent) begin
      // any traffic restarts the quiet interval
      cnt    <= '0;
      ka_req <= 1'b0;
    end else if (!busy) begin
      if (cnt == KA_LIMIT) ka_req <= 1'b1; // held until sent
      else cnt <= cnt + 1'b1;
    end
  end

endmodule : tcp_ka_timer

/* hdl/tcp_tx_arb.sv */
`timescale 1ns/100ps

`include "tcp_tx_defs.svh"

module tcp_tx_arb import tcp_tx_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       connected,
  input  tcp_port_t  loc_port,
  input  tcp_port_t  rem_port,
  input  tcp_num_t   loc_ack,
  input  tcp_num_t   last_seq,
  input  tcp_num_t   pld_seq,
  input  logic       send_pld,
  input  logic       send_ack,
  input  logic       ka_req,
  input  logic       eng_req,
  input  tcp_flags_t eng_flags,
  input  tcp_num_t   eng_seq,
  output logic       pld_sent,
  output logic       ack_sent,
  output logic       ka_sent,
  output logic       eng_done,
  output logic       busy,
  tcp_meta_if.arb    meta
);

  arb_state_t state;
  tx_kind_t   kind;      // recorded for the sent pulse
  tx_kind_t   pick;
  tcp_num_t   pick_seq;
  tcp_flags_t pick_flags;

  // priority: pld, then ka, then forced ack; eng only while not connected
  always_comb begin
    pick       = tx_none;
    pick_seq   = last_seq;
    pick_flags = `TCP_FLAG_ACK;
    if (connected) begin
      if (send_pld) begin
        pick       = tx_pld;
        pick_seq   = pld_seq;
        pick_flags = `TCP_FLAG_PSH | `TCP_FLAG_ACK;
      end else if (ka_req) begin
        pick     = tx_ka;
        pick_seq = last_seq - 32'd1; // one below, forces a reply
      end else if (send_ack) begin
        pick = tx_ack;
      end
    end else if (eng_req) begin
      pick       = tx_eng;
      pick_seq   = eng_seq;
      pick_flags = eng_flags;
    end
  end

  assign busy = (state != idle_s);

  // header fields, loaded together with rdy
  always_ff @(posedge clk) begin
    if (state == idle_s && pick != tx_none) begin
      meta.seq      <= pick_seq;
      meta.flags    <= pick_flags;
      meta.ack_num  <= loc_ack;
      meta.src_port <= loc_port;
      meta.dst_port <= rem_port;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle_s;
      kind     <= tx_none;
      meta.rdy <= 1'b0;
      pld_sent <= 1'b0;
      ack_sent <= 1'b0;
      ka_sent  <= 1'b0;
      eng_done <= 1'b0;
    end else begin
      case (state)
        idle_s: begin
          if (pick != tx_none) begin
            kind     <= pick;
            meta.rdy <= 1'b1;
            state    <= active_s;
          end
        end
        active_s: begin
          if (meta.acc) meta.rdy <= 1'b0;
          if (meta.done) begin
            case (kind)
              tx_pld:  pld_sent <= 1'b1;
              tx_ack:  ack_sent <= 1'b1;
              tx_ka:   ka_sent  <= 1'b1;
              tx_eng:  eng_done <= 1'b1;
              default: ;
            endcase
            kind  <= tx_none;
            state <= sent_s;
          end
        end
        sent_s: begin
          // pulses last one cycle, requester drops its level meanwhile
          pld_sent <= 1'b0;
          ack_sent <= 1'b0;
          ka_sent  <= 1'b0;
          eng_done <= 1'b0;
          state    <= idle_s;
        end
        default: state <= idle_s;
      endcase
    end
  end

endmodule : tcp_tx_arb

/* hdl/tcp_hdr_ser.sv */
`timescale 1ns/100ps

`include "tcp_tx_defs.svh"

module tcp_hdr_ser import tcp_tx_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  tcp_meta_if.ser meta,
  output logic    out_req,
  output byte_t   out_dat,
  output logic    out_last,
  input  logic    out_ack
);

  localparam hdr_idx_t LAST_IDX    = hdr_idx_t'(`TCP_HDR_BYTES - 1);
  localparam tcp_wnd_t WND         = `TCP_DEFAULT_WND;
  localparam byte_t    OFFSET_BYTE = {`TCP_DEFAULT_OFFSET, 4'h0};

  ser_state_t state;
  hdr_idx_t   idx;
  tcp_port_t  src_port;
  tcp_port_t  dst_port;
  tcp_num_t   seq;
  tcp_num_t   ack_num;
  tcp_flags_t flags;

  // copy of the fields, arbiter is free after acc
  always_ff @(posedge clk) begin
    if (state == ser_idle && meta.rdy) begin
      src_port <= meta.src_port;
      dst_port <= meta.dst_port;
      seq      <= meta.seq;
      ack_num  <= meta.ack_num;
      flags    <= meta.flags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ser_idle;
      idx       <= '0;
      out_req   <= 1'b0;
      meta.acc  <= 1'b0;
      meta.done <= 1'b0;
    end else begin
      meta.acc  <= 1'b0;
      meta.done <= 1'b0;
      case (state)
        ser_idle: begin
          if (meta.rdy) begin
            meta.acc <= 1'b1;
            idx      <= '0;
            out_req  <= 1'b1; // byte 0 goes up with acc
            state    <= ser_req;
          end
        end
        ser_req: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= ser_wait_low;
          end
        end
        ser_wait_low: begin
          if (!out_ack) begin
            if (idx == LAST_IDX) begin
              meta.done <= 1'b1;
              state     <= ser_done;
            end else begin
              idx     <= idx + 1'b1;
              out_req <= 1'b1;
              state   <= ser_req;
            end
          end
        end
        ser_done: state <= ser_idle;
        default:  state <= ser_idle;
      endcase
    end
  end

  // big-endian header walk
  always_comb begin
    case (idx)
      5'd0:    out_dat = src_port[15:8];
      5'd1:    out_dat = src_port[7:0];
      5'd2:    out_dat = dst_port[15:8];
      5'd3:    out_dat = dst_port[7:0];
      5'd4:    out_dat = seq[31:24];
      5'd5:    out_dat = seq[23:16];
      5'd6:    out_dat = seq[15:8];
      5'd7:    out_dat = seq[7:0];
      5'd8:    out_dat = ack_num[31:24];
      5'd9:    out_dat = ack_num[23:16];
      5'd10:   out_dat = ack_num[15:8];
      5'd11:   out_dat = ack_num[7:0];
      5'd12:   out_dat = OFFSET_BYTE;
      5'd13:   out_dat = flags;
      5'd14:   out_dat = WND[15:8];
      5'd15:   out_dat = WND[7:0];
      default: out_dat = 8'h00; // checksum and urgent pointer
    endcase
  end

  assign out_last = (idx == LAST_IDX);

endmodule : tcp_hdr_ser

/* hdl/tcp_tx_top.sv */
`timescale 1ns/100ps

module tcp_tx_top import tcp_tx_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       connected,
  input  tcp_port_t  loc_port,
  input  tcp_port_t  rem_port,
  input  tcp_num_t   loc_ack,
  input  tcp_num_t   last_seq,
  input  tcp_num_t   pld_seq,
  input  logic       send_pld,
  output logic       pld_sent,
  input  logic       send_ack,
  output logic       ack_sent,
  output logic       ka_sent,
  input  logic       eng_req,
  input  tcp_flags_t eng_flags,
  input  tcp_num_t   eng_seq,
  output logic       eng_done,
  output logic       out_req,
  input  logic       out_ack,
  output byte_t      out_dat,
  output logic       out_last
);

  logic ka_req;
  logic busy;
  logic seg_sent;

  tcp_meta_if meta ();

  // any segment on the wire counts as traffic
  assign seg_sent = pld_sent | ack_sent | ka_sent | eng_done;

  tcp_ka_timer ka_timer_inst (
    .clk       (clk),
    .rst       (rst),
    .connected (connected),
    .busy      (busy),
    .seg_sent  (seg_sent),
    .ka_req    (ka_req)
  );

  tcp_tx_arb arb_inst (
    .clk       (clk),
    .rst       (rst),
    .connected (connected),
    .loc_port  (loc_port),
    .rem_port  (rem_port),
    .loc_ack   (loc_ack),
    .last_seq  (last_seq),
    .pld_seq   (pld_seq),
    .send_pld  (send_pld),
    .send_ack  (send_ack),
    .ka_req    (ka_req),
    .eng_req   (eng_req),
    .eng_flags (eng_flags),
    .eng_seq   (eng_seq),
    .pld_sent  (pld_sent),
    .ack_sent  (ack_sent),
    .ka_sent   (ka_sent),
    .eng_done  (eng_done),
    .busy      (busy),
    .meta      (meta.arb)
  );

  tcp_hdr_ser ser_inst (
    .clk      (clk),
    .rst      (rst),
    .meta     (meta.ser),
    .out_req  (out_req),
    .out_dat  (out_dat),
    .out_last (out_last),
    .out_ack  (out_ack)
  );

endmodule : tcp_tx_top

/* tb/tcp_tx_tb.sv */
`timescale 1ns/100ps

`include "tcp_tx_defs.svh"

module tcp_tx_tb import tcp_tx_pkg::*; ();

  localparam int SEG_LIMIT  = 200;
  localparam int SLOW_LIMIT = 800;  // random ack delays stretch the segment

  logic       clk;
  logic       rst;
  logic       connected;
  tcp_port_t  loc_port;
  tcp_port_t  rem_port;
  tcp_num_t   loc_ack;
  tcp_num_t   last_seq;
  tcp_num_t   pld_seq;
  logic       send_pld;
  logic       pld_sent;
  logic       send_ack;
  logic       ack_sent;
  logic       ka_sent;
  logic       eng_req;
  tcp_flags_t eng_flags;
  tcp_num_t   eng_seq;
  logic       eng_done;
  logic       out_req;
  logic       out_ack;
  byte_t      out_dat;
  logic       out_last;

  int          val_errs = 0;
  int          misc_errs = 0;
  int          pld_cnt = 0;
  int          ack_cnt = 0;
  int          ka_cnt = 0;
  int          eng_cnt = 0;
  byte_t       rx_q[$];       // every byte seen on the output
  int          last_pos[$];   // rx_q index of each out_last
  byte_t       exp_hdr[`TCP_HDR_BYTES];
  logic [31:0] lcg_state;
  bit          rand_ack = 1'b0;
  int          ack_wait = 0;

  tcp_tx_top UUT (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // four-phase receiver collecting bytes
  always @(posedge clk) begin
    if (rst) begin
      out_ack <= 1'b0;
    end else if (out_ack) begin
      if (!out_req) out_ack <= 1'b0;
    end else if (out_req) begin
      if (ack_wait > 0) begin
        ack_wait = ack_wait - 1;
      end else begin
        rx_q.push_back(out_dat);
        if (out_last) last_pos.push_back(rx_q.size() - 1);
        out_ack <= 1'b1;
        if (rand_ack) ack_wait = next_rand() >> 29;
      end
    end
  end

  always @(posedge clk) begin
    if (pld_sent) pld_cnt = pld_cnt + 1;
    if (ack_sent) ack_cnt = ack_cnt + 1;
    if (ka_sent) ka_cnt = ka_cnt + 1;
    if (eng_done) eng_cnt = eng_cnt + 1;
  end

  task automatic compare_byte(input string name, input byte_t exp, input byte_t got);
    if (got !== exp) begin
      $display("error at %0t: %s expected 8'h%02h got 8'h%02h", $time, name, exp, got);
      val_errs++;
    end
  endtask

  task automatic compare_flags(input string name, input tcp_flags_t exp,
                               input tcp_flags_t got);
    if (got !== exp) begin
      $display("error at %0t: %s expected 8'h%02h got 8'h%02h", $time, name, exp, got);
      val_errs++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("%0t: %s counted %0d times, expected %0d", $time, what, got, exp);
      misc_errs++;
    end
  endtask

  // expected big-endian header from the field rule
  task automatic build_header(input tcp_num_t seq, input tcp_flags_t flags);
    logic [159:0] hdr;
    tcp_wnd_t     wnd;
    wnd = `TCP_DEFAULT_WND;
    hdr = {loc_port, rem_port, seq, loc_ack, `TCP_DEFAULT_OFFSET, 4'h0, flags, wnd,
           16'h0000, 16'h0000};
    for (int i = 0; i < `TCP_HDR_BYTES; i++) exp_hdr[i] = hdr[159 - 8 * i -: 8];
  endtask

  task automatic check_segment(input int n, input string tag);
    int base;
    base = n * `TCP_HDR_BYTES;
    if (rx_q.size() < base + `TCP_HDR_BYTES) begin
      $display("%0t: %s header is short, only %0d bytes", $time, tag, rx_q.size() - base);
      misc_errs++;
      return;
    end
    for (int i = 0; i < `TCP_HDR_BYTES; i++) begin
      if (i == 13) compare_flags({tag, " out_dat flags"}, exp_hdr[i], rx_q[base + i]);
      else compare_byte($sformatf("%s out_dat byte %0d", tag, i), exp_hdr[i], rx_q[base + i]);
    end
    if (last_pos.size() <= n || last_pos[n] != base + `TCP_HDR_BYTES - 1) begin
      $display("%0t: %s header has out_last on the wrong byte", $time, tag);
      misc_errs++;
    end
  endtask

  task automatic wait_sent(input tx_kind_t kind, input string what, input int limit);
    int  n;
    bit  hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < limit) begin
      @(posedge clk);
      n++;
      case (kind)
        tx_pld:  hit = pld_sent;
        tx_ack:  hit = ack_sent;
        tx_ka:   hit = ka_sent;
        default: hit = eng_done;
      endcase
    end
    if (!hit) begin
      $display("%0t: timed out after %0d cycles waiting for %s", $time, limit, what);
      misc_errs++;
    end
  endtask

  task automatic wait_bytes(input int count, input int limit);
    int n;
    n = 0;
    while (rx_q.size() < count && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rx_q.size() < count) begin
      $display("%0t: timed out, no header byte after %0d cycles", $time, limit);
      misc_errs++;
    end
  endtask

  task automatic start_test();
    rx_q.delete();
    last_pos.delete();
    pld_cnt = 0;
    ack_cnt = 0;
    ka_cnt = 0;
    eng_cnt = 0;
    @(posedge clk);
  endtask

  task automatic test_payload(input int limit);
    start_test();
    connected <= 1'b1;
    send_pld  <= 1'b1;
    wait_sent(tx_pld, "pld_sent", limit);
    send_pld <= 1'b0;
    repeat (8) @(posedge clk);
    connected <= 1'b0;
    build_header(pld_seq, `TCP_FLAG_PSH | `TCP_FLAG_ACK);
    check_segment(0, "pld");
    check_count("pld_sent", pld_cnt, 1);
    check_count("header bytes", rx_q.size(), `TCP_HDR_BYTES);
  endtask

  task automatic test_forced_ack();
    start_test();
    connected <= 1'b1;
    send_ack  <= 1'b1;
    wait_sent(tx_ack, "ack_sent", SEG_LIMIT);
    send_ack <= 1'b0;
    repeat (8) @(posedge clk);
    connected <= 1'b0;
    build_header(last_seq, `TCP_FLAG_ACK);
    check_segment(0, "ack");
    check_count("ack_sent", ack_cnt, 1);
  endtask

  // payload must win over the forced ack
  task automatic test_both();
    start_test();
    connected <= 1'b1;
    send_pld  <= 1'b1;
    send_ack  <= 1'b1;
    wait_sent(tx_pld, "pld_sent", SEG_LIMIT);
    send_pld <= 1'b0;
    wait_sent(tx_ack, "ack_sent", SEG_LIMIT);
    send_ack <= 1'b0;
    repeat (8) @(posedge clk);
    connected <= 1'b0;
    build_header(pld_seq, `TCP_FLAG_PSH | `TCP_FLAG_ACK);
    check_segment(0, "pld first");
    build_header(last_seq, `TCP_FLAG_ACK);
    check_segment(1, "ack second");
    check_count("header bytes", rx_q.size(), 2 * `TCP_HDR_BYTES);
  endtask

  task automatic test_keepalive();
    start_test();
    connected <= 1'b1;
    wait_bytes(1, `TCP_KA_TICKS + 16);
    wait_sent(tx_ka, "ka_sent", SEG_LIMIT);
    repeat (4) @(posedge clk);
    connected <= 1'b0;
    build_header(last_seq - 32'd1, `TCP_FLAG_ACK);
    check_segment(0, "ka");
    check_count("ka_sent", ka_cnt, 1);
  endtask

  task automatic test_engine();
    start_test();
    eng_flags <= 8'h02;  // syn
    eng_seq   <= 32'h1357_9bdf;
    eng_req   <= 1'b1;
    send_ack  <= 1'b1;   // must wait for connected
    wait_sent(tx_eng, "eng_done", SEG_LIMIT);
    eng_req <= 1'b0;
    repeat (12) @(posedge clk);
    build_header(eng_seq, eng_flags);
    check_segment(0, "eng");
    check_count("eng_done", eng_cnt, 1);
    check_count("ack_sent while not connected", ack_cnt, 0);
    check_count("header bytes", rx_q.size(), `TCP_HDR_BYTES);
    connected <= 1'b1;
    wait_sent(tx_ack, "ack_sent", SEG_LIMIT);
    send_ack <= 1'b0;
    repeat (4) @(posedge clk);
    connected <= 1'b0;
    build_header(last_seq, `TCP_FLAG_ACK);
    check_segment(1, "ack after connect");
    check_count("ack_sent", ack_cnt, 1);
  endtask

  task automatic test_slow_receiver();
    @(posedge clk);
    pld_seq <= next_rand();
    loc_ack <= next_rand();
    rand_ack = 1'b1;
    test_payload(SLOW_LIMIT);
    rand_ack = 1'b0;
  endtask

  initial begin
    rst       = 1'b1;
    connected = 1'b0;
    loc_port  = 16'hc350;
    rem_port  = 16'h0050;
    loc_ack   = 32'h0a0b_0c0d;
    last_seq  = 32'h7000_0010;
    pld_seq   = 32'h7000_0100;
    send_pld  = 1'b0;
    send_ack  = 1'b0;
    eng_req   = 1'b0;
    eng_flags = 8'h00;
    eng_seq   = 32'h0;
    out_ack   = 1'b0;
    lcg_state = 32'hba70_4500;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (out_req !== 1'b0 || pld_sent !== 1'b0 || ack_sent !== 1'b0 ||
        ka_sent !== 1'b0 || eng_done !== 1'b0 || UUT.ka_req !== 1'b0 ||
        UUT.meta.rdy !== 1'b0 || UUT.meta.acc !== 1'b0 || UUT.meta.done !== 1'b0) begin
      $display("%0t: an output is not low right after reset", $time);
      misc_errs++;
    end
    test_payload(SEG_LIMIT);
    test_forced_ack();
    test_both();
    test_keepalive();
    test_engine();
    test_slow_receiver();
    repeat (4) @(posedge clk);
    $display("value errors: %0d, other errors: %0d", val_errs, misc_errs);
    if (val_errs + misc_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tcp_tx_tb

/* build.f */
+incdir+hdl
hdl/tcp_tx_pkg.sv
hdl/tcp_meta_if.sv
hdl/tcp_ka_timer.sv
hdl/tcp_tx_arb.sv
hdl/tcp_hdr_ser.sv
hdl/tcp_tx_top.sv
tb/tcp_tx_tb.sv
